// File: run_sim.sh
#!/usr/bin/env bash
# build and run the adc stream testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -f sim.f --top-module tb_adc_stream -j 0
build_status=$?
if [ "$build_status" -ne 0 ]; then
    echo "verilator build failed with status $build_status"
    exit 1
fi

sim_out=$(./obj_dir/Vtb_adc_stream 2>&1)
sim_status=$?
echo "$sim_out"
if [ "$sim_status" -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

# the testbench decides, its pass line must be present
if echo "$sim_out" | grep -qx "STATUS: PASS"; then
    exit 0
fi
echo "pass line not found in simulation output"
exit 1

// File: sim.f
src/acq_pkg.sv
src/stream_pkg.sv
src/sample_wr_if.sv
src/frame_timer.sv
src/capture_sequencer.sv
src/word_packer.sv
src/stream_fifo.sv
src/adc_stream_top.sv
verification/adc_stream_assertions.sv
verification/tb_adc_stream.sv

// File: src/acq_pkg.sv
// ***************************************************************************
// acquisition side geometry: adc channels, samples and frame timing
// ***************************************************************************
package acq_pkg;

    // channel layout
    localparam int N_CHANNELS  = 8;              // total adc channels
    localparam int N_MODULES   = N_CHANNELS / 2; // each module has an a and a b channel
    localparam int SAMPLE_W    = 18;             // raw adc sample width
    localparam int PAD_W       = 6;              // zero gap between sample and count byte

    // frame timing
    localparam int FRAME_SLOTS = 25;             // adc_data_clk cycles per frame
    localparam int SLOT_W      = 5;              // enough for 0..FRAME_SLOTS-1

    // frame counter, one byte per lane over two words
    localparam int FRAME_CNT_W = 64;

    // one adc sample
    typedef logic [SAMPLE_W-1:0] sample_t;

    // slot position inside a frame
    typedef logic [SLOT_W-1:0] slot_t;

    // running frame number, dropped frames included
    typedef logic [FRAME_CNT_W-1:0] frame_cnt_t;

    // all channels of one frame, 144 bits in total
    // index 2k is module k channel a, 2k+1 is module k channel b
    typedef sample_t snapshot_t [N_CHANNELS];

endpackage

// File: src/adc_stream_top.sv
`timescale 1ns/1ps

// ***************************************************************************
// adc to stream packer, top level
// frame_timer -> capture_sequencer -> word_packer -> stream_fifo -> host
// ***************************************************************************
module adc_stream_top import acq_pkg::*, stream_pkg::*; (
    input  logic                          adc_data_clk,
    input  logic                          acq_on,         // async, active low
    input  logic [N_MODULES*SAMPLE_W-1:0] adc_a_data,     // module 0 in the low bits
    input  logic [N_MODULES*SAMPLE_W-1:0] adc_b_data,
    input  logic                          big_endian,
    output logic                          m_axis_tvalid,
    input  logic                          m_axis_tready,
    output logic [WORD_W-1:0]             m_axis_tdata,
    output logic                          m_axis_tlast
);

    sample_t adc_a_arr [N_MODULES];  // flat bus split per module
    sample_t adc_b_arr [N_MODULES];
    logic    frame_tick;
    logic    pack_lo;
    logic    pack_hi;
    logic    frame_done;

    sample_wr_if wr_if ();  // packer -> fifo, room flag back to the sequencer

    always_comb begin
        for (int k = 0; k < N_MODULES; k++) begin
            adc_a_arr[k] = adc_a_data[SAMPLE_W*k +: SAMPLE_W];
            adc_b_arr[k] = adc_b_data[SAMPLE_W*k +: SAMPLE_W];
        end
    end

    frame_timer u_frame_timer (
        .adc_data_clk (adc_data_clk),
        .acq_on       (acq_on),
        .frame_tick   (frame_tick)
    );

    capture_sequencer u_capture_sequencer (
        .adc_data_clk (adc_data_clk),
        .acq_on       (acq_on),
        .frame_tick   (frame_tick),
        .wr           (wr_if.monitor),
        .pack_lo      (pack_lo),
        .pack_hi      (pack_hi),
        .frame_done   (frame_done)
    );

    word_packer u_word_packer (
        .adc_data_clk (adc_data_clk),
        .acq_on       (acq_on),
        .adc_a_data   (adc_a_arr),
        .adc_b_data   (adc_b_arr),
        .big_endian   (big_endian),
        .pack_lo      (pack_lo),
        .pack_hi      (pack_hi),
        .frame_done   (frame_done),
        .wr           (wr_if.producer)
    );

    stream_fifo u_stream_fifo (
        .adc_data_clk  (adc_data_clk),
        .acq_on        (acq_on),
        .wr            (wr_if.consumer),
        .m_axis_tvalid (m_axis_tvalid),
        .m_axis_tready (m_axis_tready),
        .m_axis_tdata  (m_axis_tdata),
        .m_axis_tlast  (m_axis_tlast)
    );

endmodule

// File: src/capture_sequencer.sv
`timescale 1ns/1ps

// ***************************************************************************
// frame capture sequencer
// at every frame tick: either pack the frame as two words or drop it whole
// ***************************************************************************
module capture_sequencer (
    input  logic          adc_data_clk,
    input  logic          acq_on,
    input  logic          frame_tick,   // last slot of the frame
    sample_wr_if.monitor  wr,           // only the room flag is used
    output logic          pack_lo,      // snapshot + low word
    output logic          pack_hi,      // high word
    output logic          frame_done    // every frame, kept or dropped
);

    typedef enum logic [1:0] {
        WAIT_FRAME,  // idle between ticks
        PACK_LO,     // first word of the frame
        PACK_HI      // second word of the frame
    } seq_state_e;

    seq_state_e state;
    seq_state_e state_nxt;

    // next state
    always_comb begin
        state_nxt = state;
        case (state)
            WAIT_FRAME: begin
                // room for both words or nothing at all, pairs never split
                if (frame_tick && wr.has_room) begin
                    state_nxt = PACK_LO;
                end
            end
            PACK_LO: state_nxt = PACK_HI;     // always follows
            PACK_HI: state_nxt = WAIT_FRAME;  // back to idle, next tick is far away
            default: state_nxt = WAIT_FRAME;
        endcase
    end

    always_ff @(posedge adc_data_clk or negedge acq_on) begin
        if (!acq_on) begin
            state <= WAIT_FRAME;
        end else begin
            state <= state_nxt;
        end
    end

    // moore outputs, one cycle each
    assign pack_lo    = (state == PACK_LO);
    assign pack_hi    = (state == PACK_HI);

    // frame counter advances on every tick, so drops leave a gap in the count
    assign frame_done = frame_tick && (state == WAIT_FRAME);

endmodule

// File: src/frame_timer.sv
`timescale 1ns/1ps

// ***************************************************************************
// frame time base
// counts slots 0..FRAME_SLOTS-1 and flags the final slot of every frame
// ***************************************************************************
module frame_timer import acq_pkg::*; (
    input  logic adc_data_clk,
    input  logic acq_on,       // async, active low
    output logic frame_tick    // high during the last slot
);

    slot_t slot;  // current slot in the frame

    // free running slot counter, wraps at the end of each frame
    always_ff @(posedge adc_data_clk or negedge acq_on) begin
        if (!acq_on) begin
            slot <= '0;
        end else begin
            if (slot == slot_t'(FRAME_SLOTS - 1)) begin
                slot <= '0;                 // start next frame
            end else begin
                slot <= slot + 1'b1;
            end
        end
    end

    // decoded from the counter, so the first tick is
    // FRAME_SLOTS-1 cycles after reset is released
    assign frame_tick = (slot == slot_t'(FRAME_SLOTS - 1));

endmodule

// File: src/sample_wr_if.sv
`timescale 1ns/1ps

// fifo write side, strobe only: the sequencer checks room before each frame
interface sample_wr_if import stream_pkg::*; ();

    logic  wr_strobe;  // one cycle per word, no back-pressure
    word_t wr_word;    // word already in final byte order
    logic  wr_last;    // packet end
    logic  has_room;   // at least ROOM_WORDS free entries

    // word_packer side
    modport producer (output wr_strobe, output wr_word, output wr_last);

    // stream_fifo side
    modport consumer (input wr_strobe, input wr_word, input wr_last, output has_room);

    // capture_sequencer only looks at the room flag
    modport monitor (input has_room);

endinterface

// File: src/stream_fifo.sv
`timescale 1ns/1ps

// ***************************************************************************
// output fifo, first word fall through, valid/ready on the read side
// the write side is a bare strobe, room is checked upstream per frame
// ***************************************************************************
module stream_fifo import stream_pkg::*; (
    input  logic          adc_data_clk,
    input  logic          acq_on,
    sample_wr_if.consumer wr,
    output logic          m_axis_tvalid,
    input  logic          m_axis_tready,
    output word_t         m_axis_tdata,
    output logic          m_axis_tlast
);

    fifo_entry_t        mem [FIFO_DEPTH];  // storage
    logic [FIFO_AW-1:0] wr_ptr;
    logic [FIFO_AW-1:0] rd_ptr;
    fifo_level_t        level;             // entries in use
    logic               rd_en;             // beat accepted by the host
    fifo_entry_t        head;              // oldest entry

    assign rd_en = m_axis_tvalid & m_axis_tready;

    // storage write, no reset on data
    always_ff @(posedge adc_data_clk) begin
        if (wr.wr_strobe) begin
            mem[wr_ptr] <= '{data: wr.wr_word, last: wr.wr_last};
        end
    end

    // pointers and occupancy
    always_ff @(posedge adc_data_clk or negedge acq_on) begin
        if (!acq_on) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            level  <= '0;
        end else begin
            if (wr.wr_strobe) begin
                wr_ptr <= wr_ptr + 1'b1;  // wraps at FIFO_DEPTH
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr.wr_strobe, rd_en})
                2'b10:   level <= level + 1'b1;
                2'b01:   level <= level - 1'b1;
                default: level <= level;  // none, or write and read together
            endcase
        end
    end

    // fall through read port
    assign head          = mem[rd_ptr];
    assign m_axis_tvalid = (level != '0);  // first beat visible the cycle after the write
    assign m_axis_tdata  = head.data;
    assign m_axis_tlast  = head.last;

    // a whole frame needs ROOM_WORDS free slots
    assign wr.has_room = (level <= fifo_level_t'(FIFO_DEPTH - ROOM_WORDS));

endmodule

// File: src/stream_pkg.sv
// ***************************************************************************
// stream side: word layout, output fifo sizing and packet framing
// ***************************************************************************
package stream_pkg;

    // word layout
    localparam int WORD_W      = 128;             // host dma stream width
    localparam int LANE_W      = 32;              // sample + pad + count byte
    localparam int LANES       = WORD_W / LANE_W; // 4 lanes per word
    localparam int CH_PER_WORD = 4;               // one channel per lane

    // output fifo
    localparam int FIFO_DEPTH  = 16;
    localparam int FIFO_AW     = 4;               // log2(FIFO_DEPTH)
    localparam int ROOM_WORDS  = 2;               // a frame is always two words

    // packet framing
    localparam int PKT_WORDS   = 16;              // tlast on every 16th word
    localparam int PKT_CNT_W   = 4;

    // one stream beat
    typedef logic [WORD_W-1:0] word_t;

    // fifo storage entry, data plus packet end
    typedef struct packed {
        word_t data;  // stream payload
        logic  last;  // tlast for this beat
    } fifo_entry_t;

    // occupancy, needs one bit more than the pointers to tell full from empty
    typedef logic [FIFO_AW:0] fifo_level_t;

endpackage

// File: src/word_packer.sv
`timescale 1ns/1ps

// ***************************************************************************
// word packer
// takes one channel snapshot per accepted frame and emits it as two words
// lane i = {channel, 6 zero bits, count byte}, lane 0 in the low bits
// ***************************************************************************
module word_packer import acq_pkg::*, stream_pkg::*; (
    input  logic          adc_data_clk,
    input  logic          acq_on,
    input  sample_t       adc_a_data [N_MODULES],  // channel a of each module
    input  sample_t       adc_b_data [N_MODULES],  // channel b of each module
    input  logic          big_endian,              // reverse bytes of every word
    input  logic          pack_lo,
    input  logic          pack_hi,
    input  logic          frame_done,
    sample_wr_if.producer wr
);

    frame_cnt_t           frame_cnt;    // bumps on every frame, dropped ones too
    snapshot_t            snap;         // channels held for both words
    frame_cnt_t           cnt_snap;     // count of the captured frame
    logic                 endian_snap;  // byte order fixed per frame
    logic                 sel_hi;       // current write is the high word
    logic [PKT_CNT_W-1:0] word_cnt;     // position inside the packet
    word_t                word_le;      // little endian word before ordering

    // full 128 bit byte swap
    function automatic word_t swap_bytes(input word_t w);
        word_t r;
        for (int b = 0; b < WORD_W / 8; b++) begin
            r[8*b +: 8] = w[8*(WORD_W/8 - 1 - b) +: 8];
        end
        return r;
    endfunction

    // frame counter
    always_ff @(posedge adc_data_clk or negedge acq_on) begin
        if (!acq_on) begin
            frame_cnt <= '0;
        end else if (frame_done) begin
            frame_cnt <= frame_cnt + 1'b1;
        end
    end

    // snapshot, payload only
    always_ff @(posedge adc_data_clk) begin
        if (pack_lo) begin
            for (int k = 0; k < N_MODULES; k++) begin
                snap[2*k]   <= adc_a_data[k];  // even channels from side a
                snap[2*k+1] <= adc_b_data[k];  // odd channels from side b
            end
            cnt_snap    <= frame_cnt - 1'b1;    // counter stepped at the tick already
            endian_snap <= big_endian;
        end
    end

    // write strobe, word select and packet position
    always_ff @(posedge adc_data_clk or negedge acq_on) begin
        if (!acq_on) begin
            wr.wr_strobe <= 1'b0;
            sel_hi       <= 1'b0;
            word_cnt     <= '0;
        end else begin
            wr.wr_strobe <= pack_lo | pack_hi;  // one cycle behind each pack strobe
            sel_hi       <= pack_hi;
            if (wr.wr_strobe) begin
                if (word_cnt == PKT_CNT_W'(PKT_WORDS - 1)) begin
                    word_cnt <= '0;             // packet closed
                end else begin
                    word_cnt <= word_cnt + 1'b1;
                end
            end
        end
    end

    // lane assembly, channels 0..3 / bytes 0..3 low, 4..7 high
    always_comb begin
        int base;
        base    = sel_hi ? CH_PER_WORD : 0;
        word_le = '0;
        for (int i = 0; i < LANES; i++) begin
            word_le[LANE_W*i +: LANE_W] = {snap[base + i],
                                           {PAD_W{1'b0}},
                                           cnt_snap[8*(base + i) +: 8]};
        end
    end

    assign wr.wr_word = endian_snap ? swap_bytes(word_le) : word_le;
    assign wr.wr_last = (word_cnt == PKT_CNT_W'(PKT_WORDS - 1));  // every 16th word

endmodule

// File: verification/adc_stream_assertions.sv
`timescale 1ns/1ps

// ***************************************************************************
// stream_fifo checks, bound into every stream_fifo instance
// ***************************************************************************
module adc_stream_assertions import stream_pkg::*; (
    input logic        adc_data_clk,
    input logic        acq_on,
    input logic        wr_strobe,      // from the packer
    input fifo_level_t level,          // fifo occupancy
    input logic        m_axis_tvalid,
    input logic        m_axis_tready,
    input word_t       m_axis_tdata,
    input logic        m_axis_tlast
);

    // a write into a full fifo would overwrite the oldest word
    property no_write_when_full;
        @(posedge adc_data_clk) disable iff (!acq_on)
            wr_strobe |-> (level != fifo_level_t'(FIFO_DEPTH));
    endproperty

    // stalled beat keeps valid, data and last
    property hold_while_stalled;
        @(posedge adc_data_clk) disable iff (!acq_on)
            (m_axis_tvalid && !m_axis_tready) |=>
                (m_axis_tvalid && $stable(m_axis_tdata) && $stable(m_axis_tlast));
    endproperty

    // empty fifo right after reset
    property idle_after_reset;
        @(posedge adc_data_clk) $rose(acq_on) |-> !m_axis_tvalid;
    endproperty

    a_no_write_when_full: assert property (no_write_when_full)
        else $error("fifo write while full, level %0d", level);

    a_hold_while_stalled: assert property (hold_while_stalled)
        else $error("output beat changed while stalled");

    a_idle_after_reset: assert property (idle_after_reset)
        else $error("tvalid high in the first cycle after reset");

endmodule

bind stream_fifo adc_stream_assertions u_adc_stream_assertions (
    .adc_data_clk  (adc_data_clk),
    .acq_on        (acq_on),
    .wr_strobe     (wr.wr_strobe),
    .level         (level),
    .m_axis_tvalid (m_axis_tvalid),
    .m_axis_tready (m_axis_tready),
    .m_axis_tdata  (m_axis_tdata),
    .m_axis_tlast  (m_axis_tlast)
);

// File: verification/tb_adc_stream.sv
`timescale 1ns/1ps

// ***************************************************************************
// testbench for adc_stream_top
// phase table drives frames, byte order and tready, a queue model checks beats
// ***************************************************************************
module tb_adc_stream import acq_pkg::*, stream_pkg::*;;

    localparam logic [1:0] READY_ALWAYS = 2'd0;  // tready tied high
    localparam logic [1:0] READY_RANDOM = 2'd1;  // tready from the lcg
    localparam logic [1:0] READY_HOLD   = 2'd2;  // tready low, fifo fills

    typedef struct packed {
        logic [7:0] frames;      // frames in this phase
        logic       big_end;     // big_endian input
        logic [1:0] ready_mode;  // tready pattern
    } phase_t;

    localparam int N_PHASES = 6;

    // frames, big_endian, tready mode
    localparam phase_t PHASES [N_PHASES] = '{
        '{8'd4,  1'b0, READY_ALWAYS},  // first frames after reset, little endian
        '{8'd4,  1'b1, READY_ALWAYS},  // byte reversed words
        '{8'd6,  1'b0, READY_RANDOM},
        '{8'd12, 1'b0, READY_HOLD},    // fill the fifo, later frames dropped
        '{8'd10, 1'b1, READY_ALWAYS},  // drain, count jumps over the gap
        '{8'd6,  1'b0, READY_RANDOM}
    };

    logic                          adc_data_clk = 1'b0;
    logic                          acq_on;
    logic [N_MODULES*SAMPLE_W-1:0] adc_a_data;
    logic [N_MODULES*SAMPLE_W-1:0] adc_b_data;
    logic                          big_endian;
    logic                          m_axis_tvalid;
    logic                          m_axis_tready;
    logic [WORD_W-1:0]             m_axis_tdata;
    logic                          m_axis_tlast;

    logic [31:0]                   lcg_state = 32'hf9fd_99d0;
    logic [WORD_W:0]               exp_q [$];    // {tlast, tdata} in write order
    logic [N_MODULES*SAMPLE_W-1:0] a_next;       // samples for the coming frame
    logic [N_MODULES*SAMPLE_W-1:0] b_next;
    logic                          be_next;
    int cyc = 0;               // cycles since reset release
    int words_written = 0;     // for the packet position
    int frames_accepted = 0;
    int frames_dropped = 0;
    int err_data = 0;
    int err_last = 0;
    int err_other = 0;
    int timeout_limit = 0;
    int wd_cycles = 0;

    always #50 adc_data_clk = ~adc_data_clk;  // 100 ns period

    adc_stream_top u_dut (
        .adc_data_clk  (adc_data_clk),
        .acq_on        (acq_on),
        .adc_a_data    (adc_a_data),
        .adc_b_data    (adc_b_data),
        .big_endian    (big_endian),
        .m_axis_tvalid (m_axis_tvalid),
        .m_axis_tready (m_axis_tready),
        .m_axis_tdata  (m_axis_tdata),
        .m_axis_tlast  (m_axis_tlast)
    );

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // byte b of the input lands at byte 15-b
    function automatic logic [WORD_W-1:0] reverse_bytes(input logic [WORD_W-1:0] w);
        logic [WORD_W-1:0] r;
        for (int b = 0; b < WORD_W / 8; b++) begin
            r[WORD_W-8-8*b +: 8] = w[8*b +: 8];
        end
        return r;
    endfunction

    // four channels, lane 0 lowest: sample on top, 6 zeros, count byte 4*half+i
    function automatic logic [WORD_W-1:0] build_word(input logic [4*SAMPLE_W-1:0] chans,
                                                     input logic [63:0] cnt,
                                                     input int half,
                                                     input logic be);
        logic [WORD_W-1:0] w;
        for (int i = 0; i < 4; i++) begin
            w[32*i +: 32] = {chans[SAMPLE_W*i +: SAMPLE_W], 6'b0, cnt[8*(4*half+i) +: 8]};
        end
        return be ? reverse_bytes(w) : w;
    endfunction

    // ***********************************************************************
    // reference model, runs in the tick cycle
    // ***********************************************************************
    task automatic predict_frame(input logic be);
        logic [63:0]           cnt;
        logic [4*SAMPLE_W-1:0] lo_ch;
        logic [4*SAMPLE_W-1:0] hi_ch;
        logic [31:0]           r;
        for (int k = 0; k < N_MODULES; k++) begin
            r = lcg_next();
            a_next[SAMPLE_W*k +: SAMPLE_W] = r[31:14];
            r = lcg_next();
            b_next[SAMPLE_W*k +: SAMPLE_W] = r[31:14];
        end
        be_next = be;
        cnt     = 64'(cyc / FRAME_SLOTS);  // dropped frames count too
        // queue size = words written minus words read so far
        if (exp_q.size() <= FIFO_DEPTH - ROOM_WORDS) begin
            lo_ch = {b_next[SAMPLE_W +: SAMPLE_W], a_next[SAMPLE_W +: SAMPLE_W],
                     b_next[0 +: SAMPLE_W], a_next[0 +: SAMPLE_W]};          // ch 3..0
            hi_ch = {b_next[3*SAMPLE_W +: SAMPLE_W], a_next[3*SAMPLE_W +: SAMPLE_W],
                     b_next[2*SAMPLE_W +: SAMPLE_W], a_next[2*SAMPLE_W +: SAMPLE_W]};
            exp_q.push_back({(words_written % PKT_WORDS) == PKT_WORDS - 1,
                             build_word(lo_ch, cnt, 0, be)});
            words_written++;
            exp_q.push_back({(words_written % PKT_WORDS) == PKT_WORDS - 1,
                             build_word(hi_ch, cnt, 1, be)});
            words_written++;
            frames_accepted++;
        end else begin
            frames_dropped++;   // whole frame, no words
        end
    endtask

    task automatic check_output();
        logic [WORD_W:0] head;
        if (m_axis_tvalid && exp_q.size() == 0) begin
            $display("tvalid high in cycle %0d while no word is expected", cyc);
            err_other++;
        end else if (m_axis_tvalid && m_axis_tready) begin
            head = exp_q.pop_front();   // transfer at the next rising edge
            if (m_axis_tdata !== head[WORD_W-1:0]) begin
                $display("** Error: m_axis_tdata = %h, expected %h (cycle %0d)",
                         m_axis_tdata, head[WORD_W-1:0], cyc);
                err_data++;
            end
            if (m_axis_tlast !== head[WORD_W]) begin
                $display("** Error: m_axis_tlast = %h, expected %h (cycle %0d)",
                         m_axis_tlast, head[WORD_W], cyc);
                err_last++;
            end
        end
    endtask

    // check mid cycle, drive at the next rising edge
    task automatic cycle_step(input logic [1:0] mode, input logic be);
        logic        tick;
        logic [31:0] r;
        @(negedge adc_data_clk);
        tick = (cyc % FRAME_SLOTS) == FRAME_SLOTS - 1;  // slot 24
        if (tick) begin
            predict_frame(be);  // room judged before this cycle's read
        end
        check_output();
        @(posedge adc_data_clk);
        r = lcg_next();
        case (mode)
            READY_ALWAYS: m_axis_tready <= 1'b1;
            READY_RANDOM: m_axis_tready <= r[30];
            default:      m_axis_tready <= 1'b0;
        endcase
        if (tick) begin
            adc_a_data <= a_next;   // stable through the pack_lo snapshot
            adc_b_data <= b_next;
            big_endian <= be_next;
        end
        cyc++;
    endtask

    // watchdog
    always @(posedge adc_data_clk) begin
        wd_cycles <= wd_cycles + 1;
        if (wd_cycles >= timeout_limit) begin
            $display("timeout: run did not finish within %0d cycles", timeout_limit);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    initial begin
        timeout_limit = 16 + 200;
        for (int p = 0; p < N_PHASES; p++) begin
            timeout_limit += int'(PHASES[p].frames) * FRAME_SLOTS;
            if (PHASES[p].ready_mode == READY_HOLD) begin
                timeout_limit += int'(PHASES[p].frames) * FRAME_SLOTS;
            end
        end
        acq_on        <= 1'b0;
        adc_a_data    <= '0;
        adc_b_data    <= '0;
        big_endian    <= 1'b0;
        m_axis_tready <= 1'b1;
        repeat (16) @(posedge adc_data_clk);
        acq_on <= 1'b1;   // slot 0 starts after this edge

        for (int p = 0; p < N_PHASES; p++) begin
            for (int f = 0; f < int'(PHASES[p].frames); f++) begin
                repeat (FRAME_SLOTS) cycle_step(PHASES[p].ready_mode, PHASES[p].big_end);
            end
        end
        while (exp_q.size() != 0) begin
            cycle_step(READY_ALWAYS, 1'b0);   // empty out what is left
        end

        @(negedge adc_data_clk);
        if (m_axis_tvalid) begin
            $display("fifo still holds words after all expected words were read");
            err_other++;
        end
        if (frames_dropped == 0) begin
            $display("no frame was dropped while tready was held low");
            err_other++;
        end
        $display("frames accepted %0d, dropped %0d, errors: tdata %0d, tlast %0d, other %0d",
                 frames_accepted, frames_dropped, err_data, err_last, err_other);
        if (err_data + err_last + err_other == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule
